// ==== design/matrix_defs.svh ====
`ifndef MATRIX_DEFS_SVH
`define MATRIX_DEFS_SVH

// ----------------------------------------------------------------------
// Widths and port count
// ----------------------------------------------------------------------
`define MATRIX_NUM_PORTS 5          // Mapped output ports MI0..MI4
`define AHB_DATA_W       32         // HRDATA width
`define DEC_ADDR_MSB     31         // Top of decoded HADDR slice
`define DEC_ADDR_LSB     10         // Slice bottom, 1 KB granules

// ----------------------------------------------------------------------
// Region bounds in slice units
// ----------------------------------------------------------------------

// Regions are checked MI0 first, first hit wins

// MI0 at 0x20000000-0x2003ffff
`define MI0_LO 22'h080000
`define MI0_HI 22'h0800ff

// MI1 at 0x00000000-0x000fffff
`define MI1_LO 22'h000000
`define MI1_HI 22'h0003ff

// MI2 at 0x40000000-0x4000ffff
`define MI2_LO 22'h100000
`define MI2_HI 22'h10003f

// MI3 at 0x40010000-0x4001ffff
`define MI3_LO 22'h100040
`define MI3_HI 22'h10007f

// MI4 at 0x40020000-0x4002ffff
`define MI4_LO 22'h100080
`define MI4_HI 22'h1000bf

`endif

// ==== design/ahb_bus_pkg.sv ====
// AHB protocol encodings shared by the matrix decode blocks
package ahb_bus_pkg;

    // ------------------------------------------------------------------
    // Transfer kind, HTRANS
    // ------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,             // No transfer wanted
        BUSY   = 2'b01,             // Master inserts a wait in a burst
        NONSEQ = 2'b10,             // First beat or single transfer
        SEQ    = 2'b11              // Following beat of a burst
    } htrans_t;

    // ------------------------------------------------------------------
    // Slave response, HRESP
    // ------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        OKAY  = 2'b00,              // Transfer completed fine
        ERROR = 2'b01,              // Two-cycle error reply
        RETRY = 2'b10,              // Legacy AHB, not produced here
        SPLIT = 2'b11               // Legacy AHB, not produced here
    } hresp_t;

endpackage

// ==== design/matrix_map_pkg.sv ====
`include "matrix_defs.svh"

// Port selection encodings for the matrix address map
package matrix_map_pkg;

    // ------------------------------------------------------------------
    // Port count types
    // ------------------------------------------------------------------
    typedef logic [2:0] port_idx_t;                      // Mapped port number
    typedef logic [`MATRIX_NUM_PORTS-1:0] port_vec_t;    // One bit per port

    // ------------------------------------------------------------------
    // Port select word
    // ------------------------------------------------------------------

    // Field view of the select word
    typedef struct packed
    {
        logic      dflt;            // Default slave owns the transfer
        port_idx_t idx;             // Port MI0..MI4, only when dflt clear
    } port_fields_t;

    // Same four bits, seen whole or split into fields
    typedef union packed
    {
        logic [3:0]   raw;          // Plain word, as held in the register
        port_fields_t fld;          // Decoded view
    } port_sel_u;

    // Unmapped address goes to the local slave
    localparam port_sel_u PORT_DEFAULT = 4'b1000;

    // Port 0 word, also the state after reset
    localparam port_sel_u PORT_MI0 = 4'b0000;

endpackage

// ==== design/matrix_addr_decode.sv ====
`timescale 1ns/1ns
`include "matrix_defs.svh"

module matrix_addr_decode
    import ahb_bus_pkg::*;
    import matrix_map_pkg::*;
(
    input  logic [`DEC_ADDR_MSB:`DEC_ADDR_LSB] decode_addr,  // HADDR slice
    input  htrans_t                            trans_dec,    // HTRANS of input port
    input  logic                               sel_dec,      // HSEL of input port
    input  port_sel_u                          data_port,    // Port now in data phase
    input  port_vec_t                          active_mi,    // Output stage active levels
    output port_sel_u                          addr_port,    // Port for this address phase
    output port_vec_t                          sel_mi,       // One-hot port selects
    output logic                               sel_dft_slv,  // Default slave select
    output logic                               active_dec    // Active of chosen port
);

    port_vec_t hit;                 // Region match per port
    logic      idle_hold;           // Keep the data-phase port

    // ------------------------------------------------------------------
    // Region compare
    // ------------------------------------------------------------------
    assign hit[0] = (decode_addr >= `MI0_LO) && (decode_addr <= `MI0_HI);
    assign hit[1] = (decode_addr >= `MI1_LO) && (decode_addr <= `MI1_HI);
    assign hit[2] = (decode_addr >= `MI2_LO) && (decode_addr <= `MI2_HI);
    assign hit[3] = (decode_addr >= `MI3_LO) && (decode_addr <= `MI3_HI);
    assign hit[4] = (decode_addr >= `MI4_LO) && (decode_addr <= `MI4_HI);

    // IDLE to a mapped data port avoids a needless switch
    assign idle_hold = (trans_dec == IDLE) && !data_port.fld.dflt;

    // ------------------------------------------------------------------
    // Port choice
    // ------------------------------------------------------------------
    always_comb
    begin
        addr_port = PORT_DEFAULT;                   // Nothing hit
        if (idle_hold)
            addr_port = data_port;
        else
        begin
            // Walk down so the lowest matching port is written last
            for (int k = `MATRIX_NUM_PORTS - 1; k >= 0; k--)
            begin
                if (hit[k])
                begin
                    addr_port.fld.dflt = 1'b0;
                    addr_port.fld.idx  = port_idx_t'(k);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Selects and active mux
    // ------------------------------------------------------------------
    always_comb
    begin
        sel_mi      = '0;
        sel_dft_slv = 1'b0;
        if (sel_dec)                                // Only when input port is selected
        begin
            if (addr_port.fld.dflt)
                sel_dft_slv = 1'b1;
            else
                sel_mi[addr_port.fld.idx] = 1'b1;
        end
    end

    // Default slave is always ready to take the transfer
    assign active_dec = addr_port.fld.dflt ? 1'b1 : active_mi[addr_port.fld.idx];

endmodule

// ==== design/matrix_default_slave.sv ====
`timescale 1ns/1ns
`include "matrix_defs.svh"

module matrix_default_slave
    import ahb_bus_pkg::*;
(
    input  logic    HCLK,           // AHB clock
    input  logic    HRESETn,        // Sync reset, active low
    input  logic    sel_dft_slv,    // Unmapped address selected
    input  htrans_t trans_dec,      // HTRANS of input port
    input  logic    HREADYS,        // Previous transfer done
    output logic    readyout_dft,   // HREADYOUT of the default slave
    output hresp_t  resp_dft        // HRESP of the default slave
);

    // ------------------------------------------------------------------
    // Response state
    // ------------------------------------------------------------------

    // Bit 1 holds ready low, bit 0 flags ERROR
    localparam logic [1:0] ST_OKAY = 2'b00;        // Ready, OKAY
    localparam logic [1:0] ST_ERR1 = 2'b11;        // Wait, ERROR
    localparam logic [1:0] ST_ERR2 = 2'b01;        // Ready, ERROR

    logic [1:0] resp_state;
    logic [1:0] resp_next;
    logic       trans_req;          // Real transfer accepted this edge

    // IDLE and BUSY never start the error reply
    assign trans_req = sel_dft_slv && HREADYS &&
                       ((trans_dec == NONSEQ) || (trans_dec == SEQ));

    always_comb
    begin
        if (resp_state == ST_ERR1)
            resp_next = ST_ERR2;                    // Second cycle always follows
        else if (trans_req)
            resp_next = ST_ERR1;
        else
            resp_next = ST_OKAY;
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            resp_state <= ST_OKAY;
        else
            resp_state <= resp_next;
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign readyout_dft = ~resp_state[1];
    assign resp_dft     = resp_state[0] ? ERROR : OKAY;

endmodule

// ==== design/matrix_resp_mux.sv ====
`timescale 1ns/1ns
`include "matrix_defs.svh"

module matrix_resp_mux
    import ahb_bus_pkg::*;
    import matrix_map_pkg::*;
(
    input  logic                                         HCLK,         // AHB clock
    input  logic                                         HRESETn,      // Sync reset
    input  logic                                         HREADYS,      // Transfer done
    input  port_sel_u                                    addr_port,    // From decoder
    input  port_vec_t                                    readyout_mi,  // Port HREADYOUTs
    input  hresp_t [`MATRIX_NUM_PORTS-1:0]               resp_mi,      // Port HRESPs
    input  logic [`MATRIX_NUM_PORTS-1:0][`AHB_DATA_W-1:0] rdata_mi,    // Port HRDATAs
    input  logic                                         readyout_dft, // Default slave ready
    input  hresp_t                                       resp_dft,     // Default slave resp
    output port_sel_u                                    data_port,    // Data-phase port
    output logic                                         HREADYOUTS,   // Ready to input port
    output hresp_t                                       HRESPS,       // Response to input
    output logic [`AHB_DATA_W-1:0]                       HRDATAS       // Read data to input
);

    // ------------------------------------------------------------------
    // Data-phase port register
    // ------------------------------------------------------------------

    // HREADYS and not HREADYOUTS, the input stage can accept while
    // its own holding register is loading
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            data_port.raw <= PORT_MI0.raw;          // Port 0 after reset
        else if (HREADYS)
            data_port.raw <= addr_port.raw;         // Holds under back-pressure
    end

    // ------------------------------------------------------------------
    // Response and read-data mux
    // ------------------------------------------------------------------
    always_comb
    begin
        if (data_port.fld.dflt)
        begin
            HREADYOUTS = readyout_dft;
            HRESPS     = resp_dft;
            HRDATAS    = '0;                        // Nothing to read
        end
        else
        begin
            HREADYOUTS = readyout_mi[data_port.fld.idx];
            HRESPS     = resp_mi[data_port.fld.idx];
            HRDATAS    = rdata_mi[data_port.fld.idx];
        end
    end

endmodule

// ==== design/ahb_matrix_decode.sv ====
`timescale 1ns/1ns
`include "matrix_defs.svh"

module ahb_matrix_decode
    import ahb_bus_pkg::*;
    import matrix_map_pkg::*;
(
    input  logic                                         HCLK,         // AHB clock
    input  logic                                         HRESETn,      // Sync reset
    input  logic                                         HREADYS,      // Transfer done
    input  logic                                         sel_dec,      // HSEL in
    input  logic [`DEC_ADDR_MSB:`DEC_ADDR_LSB]           decode_addr,  // HADDR slice
    input  htrans_t                                      trans_dec,    // HTRANS in
    input  port_vec_t                                    active_mi,    // Stage active
    input  port_vec_t                                    readyout_mi,  // Stage ready
    input  hresp_t [`MATRIX_NUM_PORTS-1:0]               resp_mi,      // Stage resp
    input  logic [`MATRIX_NUM_PORTS-1:0][`AHB_DATA_W-1:0] rdata_mi,    // Stage data
    output port_vec_t                                    sel_mi,       // Port selects
    output logic                                         active_dec,   // Chosen active
    output logic                                         HREADYOUTS,   // Ready out
    output hresp_t                                       HRESPS,       // Response out
    output logic [`AHB_DATA_W-1:0]                       HRDATAS       // Read data out
);

    // ------------------------------------------------------------------
    // Internal wires
    // ------------------------------------------------------------------
    port_sel_u addr_port;           // Address-phase port
    port_sel_u data_port;           // Data-phase port
    logic      sel_dft_slv;         // Unmapped address
    logic      readyout_dft;
    hresp_t    resp_dft;

    matrix_addr_decode u_addr_decode
    (
        .decode_addr (decode_addr),
        .trans_dec   (trans_dec),
        .sel_dec     (sel_dec),
        .data_port   (data_port),
        .active_mi   (active_mi),
        .addr_port   (addr_port),
        .sel_mi      (sel_mi),
        .sel_dft_slv (sel_dft_slv),
        .active_dec  (active_dec)
    );

    // Runs beside the decoder on the same address phase
    matrix_default_slave u_default_slave
    (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .sel_dft_slv  (sel_dft_slv),
        .trans_dec    (trans_dec),
        .HREADYS      (HREADYS),
        .readyout_dft (readyout_dft),
        .resp_dft     (resp_dft)
    );

    matrix_resp_mux u_resp_mux
    (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .HREADYS      (HREADYS),
        .addr_port    (addr_port),
        .readyout_mi  (readyout_mi),
        .resp_mi      (resp_mi),
        .rdata_mi     (rdata_mi),
        .readyout_dft (readyout_dft),
        .resp_dft     (resp_dft),
        .data_port    (data_port),
        .HREADYOUTS   (HREADYOUTS),
        .HRESPS       (HRESPS),
        .HRDATAS      (HRDATAS)
    );

endmodule

// ==== tests/matrix_decode_properties.sv ====
`timescale 1ns/1ns
`include "matrix_defs.svh"

module matrix_decode_properties
    import ahb_bus_pkg::*;
(
    input logic                         HCLK,
    input logic                         HRESETn,
    input logic                         sel_dec,
    input logic [`MATRIX_NUM_PORTS-1:0] sel_mi,
    input logic                         HREADYOUTS,
    input logic [`MATRIX_NUM_PORTS-1:0] readyout_mi,
    input logic                         readyout_dft,   // Default slave, internal
    input hresp_t                       resp_dft
);

    int unsigned prop_fails = 0;    // Read by the testbench at the end

    // ------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------
    a_sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(sel_mi))
    else
    begin
        $error("sel_mi has more than one bit set");
        prop_fails++;
    end

    a_sel_gated: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                  !sel_dec |-> (sel_mi == '0))
    else
    begin
        $error("sel_mi set while sel_dec low");
        prop_fails++;
    end

    // ------------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------------
    a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                      (!readyout_dft && resp_dft == ERROR) |=>
                                      (readyout_dft && resp_dft == ERROR))
    else
    begin
        $error("ERROR reply not followed by its ready cycle");
        prop_fails++;
    end

    // First edge out of reset sees port 0
    a_reset_port: assert property (@(posedge HCLK)
                                   $rose(HRESETn) |-> (HREADYOUTS == readyout_mi[0]))
    else
    begin
        $error("HREADYOUTS not taken from port 0 after reset");
        prop_fails++;
    end

endmodule

bind ahb_matrix_decode matrix_decode_properties u_props
(
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .sel_dec      (sel_dec),
    .sel_mi       (sel_mi),
    .HREADYOUTS   (HREADYOUTS),
    .readyout_mi  (readyout_mi),
    .readyout_dft (readyout_dft),
    .resp_dft     (resp_dft)
);

// ==== tests/tb_matrix_decode.sv ====
`timescale 1ns/1ns
`include "matrix_defs.svh"

module tb_matrix_decode
    import ahb_bus_pkg::*;
();

    logic                                          HCLK;
    logic                                          HRESETn;
    logic                                          HREADYS;
    logic                                          sel_dec;
    logic [`DEC_ADDR_MSB:`DEC_ADDR_LSB]            decode_addr;
    htrans_t                                       trans_dec;
    logic [`MATRIX_NUM_PORTS-1:0]                  active_mi;
    logic [`MATRIX_NUM_PORTS-1:0]                  readyout_mi;
    hresp_t [`MATRIX_NUM_PORTS-1:0]                resp_mi;
    logic [`MATRIX_NUM_PORTS-1:0][`AHB_DATA_W-1:0] rdata_mi;
    logic [`MATRIX_NUM_PORTS-1:0]                  sel_mi;
    logic                                          active_dec;
    logic                                          HREADYOUTS;
    hresp_t                                        HRESPS;
    logic [`AHB_DATA_W-1:0]                        HRDATAS;

    logic [21:0] region_lo [`MATRIX_NUM_PORTS] = '{`MI0_LO, `MI1_LO, `MI2_LO, `MI3_LO, `MI4_LO};
    logic [21:0] region_hi [`MATRIX_NUM_PORTS] = '{`MI0_HI, `MI1_HI, `MI2_HI, `MI3_HI, `MI4_HI};
    logic [31:0] rng = 32'd41639;   // xorshift state
    logic [3:0]  prev_port;         // Model data-phase port as {dflt, idx}
    logic [3:0]  model_nxt;
    logic [1:0]  dft_state;         // Error reply step of the default slave model
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          test_start;

    ahb_matrix_decode DUT (.*);

    initial
    begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;    // 4 ns period
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected {dflt, idx} for one address phase
    function automatic logic [3:0] ref_port(input logic [21:0] slice, input htrans_t tr,
                                            input logic [3:0] prev);
        if (tr == IDLE && !prev[3])
            return prev;            // Idle keeps a mapped data port
        for (int k = 0; k < `MATRIX_NUM_PORTS; k++)
            if (slice >= region_lo[k] && slice <= region_hi[k])
                return {1'b0, 3'(k)};   // First hit wins
        return 4'b1000;
    endfunction

    // Mostly inside a region and sometimes anywhere
    function automatic logic [21:0] pick_slice(input logic [31:0] r);
        int p;
        p = r[29:27] % `MATRIX_NUM_PORTS;
        if (r[31:30] == 2'b00)
            return r[21:0];
        return region_lo[p] + 22'(r[21:0] % (region_hi[p] - region_lo[p] + 1));
    endfunction

    // Model state follows the edges like the data-phase register
    always @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            prev_port <= 4'h0;
            dft_state <= 2'd0;
        end
        else
        begin
            model_nxt = ref_port(decode_addr, trans_dec, prev_port);
            if (dft_state == 2'd1)
                dft_state <= 2'd2;  // Second error cycle unconditional
            else if (sel_dec && HREADYS && model_nxt[3] && trans_dec[1])
                dft_state <= 2'd1;  // NONSEQ or SEQ to unmapped space
            else
                dft_state <= 2'd0;
            if (HREADYS)
                prev_port <= model_nxt;
        end
    end

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Outputs settle 1 ns after the falling-edge drive
    initial
    begin : compare_proc
        logic [3:0] exp_port;
        logic [4:0] exp_sel;
        forever
        begin
            @(negedge HCLK);
            #1;
            if (HRESETn)
            begin
                exp_port = ref_port(decode_addr, trans_dec, prev_port);
                exp_sel  = (sel_dec && !exp_port[3]) ? (5'b1 << exp_port[2:0]) : 5'b0;
                check_value("sel_mi", sel_mi, exp_sel);
                check_value("active_dec", active_dec,
                            exp_port[3] ? 1'b1 : active_mi[exp_port[2:0]]);
                if (prev_port[3])
                begin
                    check_value("HREADYOUTS", HREADYOUTS, dft_state != 2'd1);
                    check_value("HRESPS", HRESPS, (dft_state != 2'd0) ? ERROR : OKAY);
                    check_value("HRDATAS", HRDATAS, '0);
                end
                else
                begin
                    check_value("HREADYOUTS", HREADYOUTS, readyout_mi[prev_port[2:0]]);
                    check_value("HRESPS", HRESPS, resp_mi[prev_port[2:0]]);
                    check_value("HRDATAS", HRDATAS, rdata_mi[prev_port[2:0]]);
                end
            end
        end
    end

    always @(posedge HCLK)
    begin
        cycles++;
        if (cycles >= 400)          // About twice the total test length
        begin
            $display("Run stopped: cycle limit of 400 reached before the tests ended");
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic drive(input logic [21:0] slice, input htrans_t tr, input logic sel,
                         input logic rdy);
        @(negedge HCLK);
        decode_addr = slice;
        trans_dec   = tr;
        sel_dec     = sel;
        HREADYS     = rdy;
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial
    begin
        HRESETn     = 1'b0;
        HREADYS     = 1'b1;
        sel_dec     = 1'b0;
        decode_addr = '0;
        trans_dec   = IDLE;
        active_mi   = '1;
        readyout_mi = 5'b11110;     // Port 0 ready low makes the reset check visible
        test_start  = 0;
        for (int k = 0; k < `MATRIX_NUM_PORTS; k++)
        begin
            rng         = xorshift32(rng);
            rdata_mi[k] = rng;
            rng         = xorshift32(rng);
            resp_mi[k]  = hresp_t'(rng[1:0]);
        end
        repeat (5) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        // Reset state with no transfer
        drive('0, IDLE, 1'b0, 1'b1);
        #1;
        check_value("HREADYOUTS", HREADYOUTS, readyout_mi[0]);
        check_value("HRDATAS", HRDATAS, rdata_mi[0]);
        end_test("reset");
        @(negedge HCLK);
        readyout_mi = '1;

        // Region bounds first and then random slices
        for (int i = 0; i < 70; i++)
        begin
            rng = xorshift32(rng);
            if (i < 10)
                decode_addr = (i % 2) ? region_hi[i / 2] : region_lo[i / 2];
            drive((i < 10) ? decode_addr : pick_slice(rng), NONSEQ, 1'b1, 1'b1);
            drive(decode_addr, NONSEQ, 1'b0, 1'b1);
        end
        end_test("region_decode");

        for (int i = 0; i < 30; i++)
        begin
            rng = xorshift32(rng);
            drive(pick_slice(rng), NONSEQ, 1'b1, 1'b1);
            active_mi = rng[12:8];
        end
        active_mi = '1;
        end_test("active_mux");

        // Back-pressure keeps MI3 in the data phase
        drive(`MI3_LO, NONSEQ, 1'b1, 1'b1);
        readyout_mi = 5'b10111;     // Port 3 ready low tells the ports apart
        drive(`MI1_LO, NONSEQ, 1'b1, 1'b0);
        #1 check_value("HRDATAS", HRDATAS, rdata_mi[3]);
        drive(`MI1_LO, NONSEQ, 1'b1, 1'b0);
        #1 check_value("HRESPS", HRESPS, resp_mi[3]);
        drive(`MI1_LO, NONSEQ, 1'b1, 1'b1);
        #1 check_value("HRDATAS", HRDATAS, rdata_mi[3]);
        drive(`MI1_LO, IDLE, 1'b0, 1'b1);
        readyout_mi = '1;
        #1 check_value("HRDATAS", HRDATAS, rdata_mi[1]);
        end_test("data_steering");

        // Two-cycle ERROR and then OKAY for IDLE
        drive(22'h3fffff, NONSEQ, 1'b1, 1'b1);
        drive(22'h3fffff, IDLE, 1'b1, 1'b0);
        #1 check_value("HREADYOUTS", HREADYOUTS, 1'b0);
        check_value("HRESPS", HRESPS, ERROR);
        check_value("HRDATAS", HRDATAS, '0);
        drive(22'h3fffff, IDLE, 1'b1, 1'b1);
        #1 check_value("HREADYOUTS", HREADYOUTS, 1'b1);
        check_value("HRESPS", HRESPS, ERROR);
        check_value("HRDATAS", HRDATAS, '0);
        drive(22'h3fffff, IDLE, 1'b1, 1'b1);
        #1 check_value("HREADYOUTS", HREADYOUTS, 1'b1);
        check_value("HRESPS", HRESPS, OKAY);
        end_test("default_slave");

        drive(`MI2_LO + 22'd5, NONSEQ, 1'b1, 1'b1);
        drive(`MI0_LO, IDLE, 1'b1, 1'b1);
        #1 check_value("sel_mi", sel_mi, 5'b00100);
        drive(`MI0_LO, IDLE, 1'b0, 1'b1);
        #1 check_value("HRDATAS", HRDATAS, rdata_mi[2]);
        end_test("idle_hold");

        repeat (2) @(negedge HCLK);
        errors = errors + DUT.u_props.prop_fails;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== matrix_decode.f ====
+incdir+design
design/ahb_bus_pkg.sv
design/matrix_map_pkg.sv
design/matrix_addr_decode.sv
design/matrix_default_slave.sv
design/matrix_resp_mux.sv
design/ahb_matrix_decode.sv
tests/matrix_decode_properties.sv
tests/tb_matrix_decode.sv
